// File: sources.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/issue_stage.sv
logic/exe_stage.sv
logic/wb_stage.sv
logic/mini_core.sv
test/mini_core_sva.sv
test/mini_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mini_core_tb
SEED_ARGS ?= +verilator+seed+19411
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f sources.f --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

// File: test/mini_core_tb.sv
`include "core_macros.svh"

module mini_core_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 3;
    localparam int N_RESET       = 31;
    localparam int N_RAND        = 200;
    localparam int N_CHAIN       = 30;  // per distance
    localparam int N_FILL        = 8;
    localparam int N_LOAD_PAIRS  = 40;
    localparam int N_STORE_ITER  = 40;
    localparam int TOTAL_INSTS   = N_RESET + N_RAND + 3 * N_CHAIN + 2 * N_FILL
                                 + 2 * N_LOAD_PAIRS + 5 * N_STORE_ITER;
    localparam int MARGIN_CYCLES = 100;
    localparam int TIMEOUT       = (4 * TOTAL_INSTS + MARGIN_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        logic        wen;
        reg_addr_t   wnum;
        word_t       wdata;
        logic [31:0] cycle;  // cycle of acceptance
    } expect_t;

    logic      aclk;
    logic      reset;
    logic      inst_valid;
    inst_t     inst;
    logic      inst_ready;
    trace_t    trace;

    integer    seed = 19411;
    int        cycle;
    int        checks;
    int        errors;
    int        retired;
    int        stalls;
    int        tests_run;
    int        err_base;
    int        ret_base;
    logic      will_accept;
    logic      last_load_valid;  // load accepted last cycle and now in exe
    reg_addr_t last_load_rd;
    word_t     mreg [0:(1 << `CORE_REG_ADDR_W)-1];
    word_t     mmem [0:`CORE_DMEM_WORDS-1];
    expect_t   exp_q [$];

    mini_core UUT (
        .aclk       (aclk      ),
        .reset      (reset     ),
        .inst_valid (inst_valid),
        .inst       (inst      ),
        .inst_ready (inst_ready),
        .trace      (trace     )
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic inst_t make_inst(input op_e op, input reg_addr_t rd,
                                        input reg_addr_t rs, input reg_addr_t rt,
                                        input imm_t imm);
        inst_t i;
        i.op  = op;
        i.rd  = rd;
        i.rs  = rs;
        i.rt  = rt;
        i.imm = imm;
        return i;
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    // architectural model applied one instruction at a time in program order
    task automatic model_apply(input inst_t i);
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     addr;
        word_t     res;
        dmem_idx_t idx;
        expect_t   e;
        a    = mreg[i.rs];
        b    = mreg[i.rt];
        imm  = {{(`CORE_XLEN - `CORE_IMM_W){i.imm[`CORE_IMM_W-1]}}, i.imm};
        addr = a + imm;
        idx  = addr[`CORE_DMEM_ADDR_W+1:2];  // word index wraps modulo memory size
        res  = '0;
        case (i.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + imm;
            OP_LW:   res = mmem[idx];
            default: mmem[idx] = b;
        endcase
        e.wen   = i.op != OP_SW && i.rd != '0;
        e.wnum  = i.rd;
        e.wdata = res;
        e.cycle = cycle;
        if (e.wen) begin
            mreg[i.rd] = res;
        end
        exp_q.push_back(e);
    endtask

    // sampled mid-cycle when all DUT outputs have settled
    always @(negedge aclk) begin
        expect_t e;
        logic    exp_ready;
        if (!reset) begin
            if (trace.retire) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected retire at time %0t with nothing in flight", $time);
                end else begin
                    e = exp_q.pop_front();
                    retired++;
                    check_value(word_t'(trace.rf.wen), word_t'(e.wen), "trace wen");
                    if (e.wen) begin
                        check_value(word_t'(trace.rf.wnum), word_t'(e.wnum), "trace wnum");
                        check_value(trace.rf.wdata, e.wdata, "trace wdata");
                    end
                    check_value(word_t'(cycle), e.cycle + 32'd2, "retire latency");
                end
            end
            exp_ready = 1'b1;
            if (inst_valid && last_load_valid) begin
                if (last_load_rd == inst.rs || (last_load_rd == inst.rt
                    && inst.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SW})) begin
                    exp_ready = 1'b0;
                end
            end
            check_value(word_t'(inst_ready), word_t'(exp_ready), "inst_ready");
            if (!inst_ready) begin
                stalls++;
            end
            will_accept     = inst_valid && inst_ready;
            last_load_valid = will_accept && inst.op == OP_LW && inst.rd != '0;
            last_load_rd    = inst.rd;
            if (will_accept) begin
                model_apply(inst);
            end
            cycle++;
        end
    end

    task automatic send_inst(input inst_t i);
        inst_valid <= 1'b1;
        inst       <= i;
        @(posedge aclk);
        while (!will_accept) @(posedge aclk);
    endtask

    task automatic start_test();
        err_base = errors;
        ret_base = retired;
    endtask

    task automatic finish_test(input string name);
        inst_valid <= 1'b0;
        @(posedge aclk);
        while (exp_q.size() != 0) @(posedge aclk);
        tests_run++;
        $display("test %s finished: %0d retired, %0d errors",
                 name, retired - ret_base, errors - err_base);
    endtask

    task automatic regs_zero_after_reset();
        start_test();
        for (int r = 1; r < 32; r++) begin  // or r, r, r reads each register twice
            send_inst(make_inst(OP_OR, reg_addr_t'(r), reg_addr_t'(r), reg_addr_t'(r), '0));
        end
        finish_test("reset_regs");
    endtask

    task automatic random_alu_sequence();
        word_t w;
        start_test();
        for (int n = 0; n < N_RAND; n++) begin
            w = rand_word();
            send_inst(make_inst(op_e'(w[2:0] % 3'd6), w[7:3], w[12:8], w[17:13], w[31:16]));
        end
        finish_test("random_alu");
    endtask

    // distance 1 hits exe, 2 hits wb and 3 the register file
    task automatic dependent_chains();
        word_t     w;
        reg_addr_t dst;
        start_test();
        for (int d = 1; d <= 3; d++) begin
            for (int n = 0; n < N_CHAIN; n++) begin
                w   = rand_word();
                dst = reg_addr_t'(1 + n % d);
                send_inst(make_inst(op_e'(w[2:0] % 3'd6), dst, dst,
                                    w[3] ? dst : w[8:4], w[31:16]));
            end
        end
        finish_test("chains");
    endtask

    task automatic load_use_interlock();
        word_t     w;
        reg_addr_t ld;
        reg_addr_t ya;
        reg_addr_t yb;
        reg_addr_t yc;
        int        deps;
        int        stall_base;
        start_test();
        deps       = 0;
        stall_base = stalls;
        for (int k = 0; k < N_FILL; k++) begin
            send_inst(make_inst(OP_ADDI, 5'd1, 5'd0, 5'd0, imm_t'(rand_word())));
            send_inst(make_inst(OP_SW, 5'd0, 5'd0, 5'd1, imm_t'(4 * k)));
        end
        for (int n = 0; n < N_LOAD_PAIRS; n++) begin
            w  = rand_word();
            ld = reg_addr_t'(8 + w[2:0]);  // loads land in r8..r15 and users in r16..r23
            ya = reg_addr_t'(16 + w[5:3]);
            yb = reg_addr_t'(16 + w[8:6]);
            yc = reg_addr_t'(16 + w[11:9]);
            send_inst(make_inst(OP_LW, ld, 5'd0, yc, imm_t'(4 * w[14:12])));
            case (w[17:15])
                3'd0: send_inst(make_inst(OP_ADD, ya, ld, yb, '0));
                3'd1: send_inst(make_inst(OP_XOR, ya, yb, ld, '0));
                3'd2: send_inst(make_inst(OP_SW, ya, 5'd0, ld, imm_t'(4 * w[20:18])));
                3'd3: send_inst(make_inst(OP_LW, ya, ld, yb, '0));
                3'd4: send_inst(make_inst(OP_ADDI, ya, yb, ld, w[31:16]));  // rt unused
                default: send_inst(make_inst(OP_SUB, ya, yb, yc, '0));
            endcase
            if (w[17:15] < 3'd4) begin
                deps++;
            end
        end
        check_value(word_t'(stalls - stall_base), word_t'(deps), "load-use stall cycles");
        finish_test("load_use");
    endtask

    task automatic store_load_pairs();
        word_t w;
        imm_t  imm_a;
        imm_t  imm_b;
        start_test();
        for (int n = 0; n < N_STORE_ITER; n++) begin
            w     = rand_word();
            imm_a = w[31:16];
            imm_b = imm_a + {6'd0, w[1:0], 8'd0};  // same word after wrap
            if (w[3:2] == 2'd0) begin
                imm_b = w[15:0];
            end
            send_inst(make_inst(OP_ADDI, 5'd7, 5'd0, 5'd0, imm_t'(rand_word())));
            send_inst(make_inst(OP_ADDI, 5'd5, 5'd0, 5'd0, imm_t'(rand_word())));
            send_inst(make_inst(OP_SW, w[8:4], 5'd7, 5'd5, imm_a));
            send_inst(make_inst(OP_LW, 5'd6, 5'd7, 5'd0, imm_b));
            send_inst(make_inst(OP_LW, 5'd10, 5'd7, 5'd0, imm_t'(rand_word())));
        end
        finish_test("store_load");
    endtask

    initial begin
        reset           = 1'b1;
        inst_valid      = 1'b0;
        inst            = '0;
        will_accept     = 1'b0;
        last_load_valid = 1'b0;
        last_load_rd    = '0;
        cycle           = 0;
        checks          = 0;
        errors          = 0;
        retired         = 0;
        stalls          = 0;
        tests_run       = 0;
        for (int i = 0; i < (1 << `CORE_REG_ADDR_W); i++) begin
            mreg[i] = '0;
        end
        for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
            mmem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        reset <= 1'b0;
        regs_zero_after_reset();
        random_alu_sequence();
        dependent_chains();
        load_use_interlock();
        store_load_pairs();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: pipeline stopped retiring after %0d time units", TIMEOUT);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: test/mini_core_sva.sv
module mini_core_sva (
    input logic             aclk,
    input logic             reset,
    input logic             inst_valid,
    input logic             inst_ready,
    input pipe_pkg::trace_t trace
);
    logic accept;

    assign accept = inst_valid && inst_ready;

    // pipeline is empty for two cycles once reset drops
    quiet_after_reset: assert property (@(posedge aclk)
        !reset && ($past(reset) || $past(reset, 2)) |-> !trace.retire)
        else $error("retire within two cycles of reset release");

    retire_after_accept: assert property (@(posedge aclk) disable iff (reset)
        $past(accept, 2) |-> trace.retire)
        else $error("accepted instruction did not retire two cycles later");

    retire_has_accept: assert property (@(posedge aclk) disable iff (reset)
        trace.retire |-> $past(accept, 2))
        else $error("retire without an acceptance two cycles earlier");

    // only a load accepted last cycle can stall issue
    stall_after_accept: assert property (@(posedge aclk) disable iff (reset)
        !inst_ready |-> $past(accept))
        else $error("inst_ready low without an acceptance in the previous cycle");

endmodule

bind mini_core mini_core_sva sva (
    .aclk       (aclk      ),
    .reset      (reset     ),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .trace      (trace     )
);

// File: logic/mini_core.sv
module mini_core (
    input  logic             aclk,
    input  logic             reset,
    input  logic             inst_valid,
    input  isa_pkg::inst_t   inst,
    output logic             inst_ready,
    output pipe_pkg::trace_t trace
);
    import isa_pkg::*;
    import pipe_pkg::*;

    reg_addr_t     rs_addr;
    reg_addr_t     rt_addr;
    word_t         rs_data;
    word_t         rt_data;
    word_t         load_data;
    exe_fwd_t      exe_fwd;
    rf_write_t     rf_write;        // also the wb forwarding source
    logic          issue_valid;
    issue_to_exe_t issue_bus;
    logic          wb_valid;
    exe_to_wb_t    wb_bus;

    reg_file reg_file (
        .aclk     (aclk    ),
        .reset    (reset   ),
        .rs_addr  (rs_addr ),
        .rt_addr  (rt_addr ),
        .rs_data  (rs_data ),
        .rt_data  (rt_data ),
        .rf_write (rf_write)
    );

    issue_stage issue_stage (
        .inst_valid  (inst_valid ),
        .inst        (inst       ),
        .inst_ready  (inst_ready ),
        .rs_addr     (rs_addr    ),
        .rt_addr     (rt_addr    ),
        .rs_data     (rs_data    ),
        .rt_data     (rt_data    ),
        .exe_fwd     (exe_fwd    ),
        .rf_write    (rf_write   ),
        .issue_valid (issue_valid),
        .issue_bus   (issue_bus  )
    );

    exe_stage exe_stage (
        .aclk        (aclk       ),
        .reset       (reset      ),
        .issue_valid (issue_valid),
        .issue_bus   (issue_bus  ),
        .exe_fwd     (exe_fwd    ),
        .wb_valid    (wb_valid   ),
        .wb_bus      (wb_bus     ),
        .load_data   (load_data  )
    );

    wb_stage wb_stage (
        .aclk      (aclk     ),
        .reset     (reset    ),
        .wb_valid  (wb_valid ),
        .wb_bus    (wb_bus   ),
        .load_data (load_data),
        .rf_write  (rf_write ),
        .trace     (trace    )
    );

endmodule

// File: logic/wb_stage.sv
module wb_stage (
    input  logic                 aclk,
    input  logic                 reset,
    input  logic                 wb_valid,
    input  pipe_pkg::exe_to_wb_t wb_bus,
    input  isa_pkg::word_t       load_data,
    output pipe_pkg::rf_write_t  rf_write,
    output pipe_pkg::trace_t     trace
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic       ws_valid;
    exe_to_wb_t ws_bus;
    word_t      final_result;

    always_ff @(posedge aclk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= wb_valid;
        end
    end

    always_ff @(posedge aclk) begin
        ws_bus <= wb_bus;
    end

    // memory word for lw, alu value for everything else
    assign final_result = ws_bus.is_load ? load_data : ws_bus.alu_value;

    always_comb begin
        rf_write.wen   = ws_valid && ws_bus.writes_reg;  // stores and r0 stay quiet
        rf_write.wnum  = ws_bus.dest;
        rf_write.wdata = final_result;
    end

    // retire marks every instruction, even one that writes nothing
    assign trace.retire = ws_valid;
    assign trace.rf     = rf_write;

endmodule

// File: logic/exe_stage.sv
`include "core_macros.svh"

module exe_stage (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  pipe_pkg::issue_to_exe_t issue_bus,
    output pipe_pkg::exe_fwd_t      exe_fwd,
    output logic                    wb_valid,
    output pipe_pkg::exe_to_wb_t    wb_bus,
    output isa_pkg::word_t          load_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic          exe_valid;
    issue_to_exe_t exe_reg;
    word_t         alu_result;
    logic          is_load;
    logic          is_store;
    dmem_idx_t     dmem_idx;
    word_t         dmem [0:`CORE_DMEM_WORDS-1];

    // writeback always accepts, so a new instruction enters every cycle
    always_ff @(posedge aclk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= issue_valid;
        end
    end

    always_ff @(posedge aclk) begin
        exe_reg <= issue_bus;
    end

    always_comb begin
        case (exe_reg.op)
            OP_ADD:              alu_result = exe_reg.rs_value + exe_reg.rt_value;
            OP_SUB:              alu_result = exe_reg.rs_value - exe_reg.rt_value;
            OP_AND:              alu_result = exe_reg.rs_value & exe_reg.rt_value;
            OP_OR:               alu_result = exe_reg.rs_value | exe_reg.rt_value;
            OP_XOR:              alu_result = exe_reg.rs_value ^ exe_reg.rt_value;
            OP_ADDI, OP_LW, OP_SW: alu_result = exe_reg.rs_value + exe_reg.imm;
            default:             alu_result = '0;
        endcase
    end

    assign is_load  = exe_reg.op == OP_LW;
    assign is_store = exe_reg.op == OP_SW;

    // byte offset dropped, wraps modulo the memory size
    assign dmem_idx = alu_result[`CORE_DMEM_ADDR_W+1:2];

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (exe_valid && is_store) begin
            dmem[dmem_idx] <= exe_reg.rt_value;
        end
    end

    // synchronous read, lands in the wb cycle
    always_ff @(posedge aclk) begin
        if (exe_valid && is_load) begin
            load_data <= dmem[dmem_idx];
        end
    end

    assign exe_fwd = '{valid: exe_valid, is_load: is_load, dest: exe_reg.rd, value: alu_result};

    assign wb_valid          = exe_valid;
    assign wb_bus.is_load    = is_load;
    assign wb_bus.dest       = exe_reg.rd;
    assign wb_bus.writes_reg = !is_store && exe_reg.rd != '0;
    assign wb_bus.alu_value  = alu_result;

endmodule

// File: logic/issue_stage.sv
module issue_stage (
    input  logic                    inst_valid,
    input  isa_pkg::inst_t          inst,
    output logic                    inst_ready,
    output isa_pkg::reg_addr_t      rs_addr,
    output isa_pkg::reg_addr_t      rt_addr,
    input  isa_pkg::word_t          rs_data,
    input  isa_pkg::word_t          rt_data,
    input  pipe_pkg::exe_fwd_t      exe_fwd,
    input  pipe_pkg::rf_write_t     rf_write,
    output logic                    issue_valid,
    output pipe_pkg::issue_to_exe_t issue_bus
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic  uses_rt;
    logic  rs_hit_load;
    logic  rt_hit_load;
    logic  load_use;
    word_t rs_value;
    word_t rt_value;

    // exe first, then wb, then the register file
    function automatic word_t fwd_select(
        input reg_addr_t num,
        input word_t     rf_value,
        input exe_fwd_t  exe,
        input rf_write_t wb
    );
        word_t result;
        if (num == '0) begin
            result = '0;
        end else if (exe.valid && !exe.is_load && exe.dest == num) begin
            result = exe.value;
        end else if (wb.wen && wb.wnum == num) begin
            result = wb.wdata;
        end else begin
            result = rf_value;
        end
        return result;
    endfunction

    always_comb begin
        case (inst.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SW: uses_rt = 1'b1;
            default:                                      uses_rt = 1'b0;  // addi, lw
        endcase
    end

    assign rs_addr = inst.rs;
    assign rt_addr = inst.rt;

    // load result only exists in wb, so hold the consumer one cycle
    assign rs_hit_load = exe_fwd.dest == inst.rs;
    assign rt_hit_load = uses_rt && exe_fwd.dest == inst.rt;

    assign load_use = inst_valid && exe_fwd.valid && exe_fwd.is_load
                   && exe_fwd.dest != '0 && (rs_hit_load || rt_hit_load);

    assign inst_ready  = !load_use;
    assign issue_valid = inst_valid && !load_use;  // bubble while stalled

    assign rs_value = fwd_select(inst.rs, rs_data, exe_fwd, rf_write);
    assign rt_value = fwd_select(inst.rt, rt_data, exe_fwd, rf_write);

    always_comb begin
        issue_bus.op       = inst.op;
        issue_bus.rd       = (inst.op == OP_SW) ? '0 : inst.rd;  // stores never write
        issue_bus.rs_value = rs_value;
        issue_bus.rt_value = rt_value;
        issue_bus.imm      = word_t'(signed'(inst.imm));
    end

endmodule

// File: logic/reg_file.sv
`include "core_macros.svh"

module reg_file (
    input  logic               aclk,
    input  logic               reset,
    input  isa_pkg::reg_addr_t rs_addr,
    input  isa_pkg::reg_addr_t rt_addr,
    output isa_pkg::word_t     rs_data,
    output isa_pkg::word_t     rt_data,
    input  pipe_pkg::rf_write_t rf_write
);
    import isa_pkg::*;

    localparam int NUM_REGS = 1 << `CORE_REG_ADDR_W;

    word_t regs [0:NUM_REGS-1];

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write.wen && rf_write.wnum != '0) begin
            regs[rf_write.wnum] <= rf_write.wdata;
        end
    end

    // old value during a write, wb forwards the new one
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: logic/pipe_pkg.sv
`include "core_macros.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef logic [`CORE_DMEM_ADDR_W-1:0] dmem_idx_t;

    // issue -> exe, operands already forwarded
    typedef struct packed {
        op_e       op;
        reg_addr_t rd;       // zero for sw
        word_t     rs_value;
        word_t     rt_value;
        word_t     imm;      // sign extended
    } issue_to_exe_t;

    // what issue sees of the instruction in exe
    typedef struct packed {
        logic      valid;
        logic      is_load;  // value not ready yet
        reg_addr_t dest;
        word_t     value;
    } exe_fwd_t;

    typedef struct packed {
        logic      is_load;
        reg_addr_t dest;
        logic      writes_reg;
        word_t     alu_value;
    } exe_to_wb_t;

    typedef struct packed {
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } rf_write_t;

    // debug view of every retiring instruction
    typedef struct packed {
        logic      retire;
        rf_write_t rf;
    } trace_t;

endpackage

// File: logic/isa_pkg.sv
`include "core_macros.svh"

package isa_pkg;

    typedef logic [`CORE_XLEN-1:0]       word_t;
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`CORE_IMM_W-1:0]      imm_t;

    // register-register ops first, then the immediate forms
    typedef enum logic [`CORE_OP_W-1:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5,
        OP_LW   = 3'd6,
        OP_SW   = 3'd7
    } op_e;

    // sw takes its data from rt, rd is ignored
    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        imm_t      imm;
    } inst_t;

endpackage

// File: logic/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path
`define CORE_XLEN           32
`define CORE_REG_ADDR_W     5
`define CORE_IMM_W          16

// opcode field width, eight operations
`define CORE_OP_W           3

// data memory, word indexed
`define CORE_DMEM_ADDR_W    6
`define CORE_DMEM_WORDS     (1 << `CORE_DMEM_ADDR_W)

`endif
